/* design/ccu_perf_counters.sv */
`timescale 1ns/1ps

module ccu_perf_counters (
  input  logic                clk,
  input  logic                rst,
  input  logic                busy,
  input  logic                pckt_last,
  input  logic                done_set,
  input  logic                progress_clear,
  output ccu_pkg::ccu_count_t iter_timer,
  output ccu_pkg::ccu_count_t iter_latency,
  output ccu_pkg::ccu_count_t oper_timer,
  output ccu_pkg::ccu_count_t oper_latency
);

  ccu_pkg::ccu_count_t iter_lat_q;
  ccu_pkg::ccu_count_t oper_lat_q;
  ccu_pkg::ccu_count_t iter_span;

  // Cycles of the current iteration including the closing beat
  assign iter_span = iter_timer + 32'd1;

  always_ff @(posedge clk) begin
    if (rst || progress_clear) begin
      iter_timer <= '0;
      oper_timer <= '0;
      iter_lat_q <= '0;
      oper_lat_q <= '0;
    end else begin
      if (busy) begin
        oper_timer <= oper_timer + 32'd1;
        if (pckt_last) begin
          iter_lat_q <= iter_span;
          iter_timer <= '0;
        end else begin
          iter_timer <= iter_timer + 32'd1;
        end
      end
      if (done_set) begin
        oper_lat_q <= oper_timer;
      end
    end
  end

  // Forward the new latency in the capture cycle so the register file
  // stores the fresh value on the same edge
  assign iter_latency = (busy && pckt_last) ? iter_span : iter_lat_q;
  assign oper_latency = done_set ? oper_timer : oper_lat_q;

endmodule

/* design/ccu_pkg.sv */
package ccu_pkg;

  typedef logic [31:0] ccu_word_t;
  typedef logic [31:0] ccu_count_t;
  typedef logic [7:0]  ccu_offset_t;
  typedef logic [4:0]  ccu_status_t;

  localparam int REG_WORDS = 16;

  // Byte offsets of the register map
  localparam ccu_offset_t REG_DATA_LEN = 8'h00;
  localparam ccu_offset_t REG_GRID_LEN = 8'h04;
  localparam ccu_offset_t REG_SCLE_LEN = 8'h08;
  localparam ccu_offset_t REG_RSLT_LEN = 8'h0C;
  localparam ccu_offset_t REG_PCKT_LEN = 8'h10;
  localparam ccu_offset_t REG_LOADED   = 8'h14;
  localparam ccu_offset_t REG_OPER_STR = 8'h18;
  localparam ccu_offset_t REG_INTR     = 8'h1C;
  localparam ccu_offset_t REG_OPER_DNE = 8'h20;
  localparam ccu_offset_t REG_OPER_STS = 8'h24;
  localparam ccu_offset_t REG_RSLT_PRG = 8'h28;
  localparam ccu_offset_t REG_ITER_PRG = 8'h2C;
  localparam ccu_offset_t REG_ITER_TMR = 8'h30;
  localparam ccu_offset_t REG_ITER_LAT = 8'h34;
  localparam ccu_offset_t REG_OPER_TMR = 8'h38;
  localparam ccu_offset_t REG_OPER_LAT = 8'h3C;

  // Field positions in REG_LOADED, REG_INTR and REG_OPER_STS
  localparam int LD_DATA    = 0;
  localparam int LD_GRID    = 1;
  localparam int LD_SCLE    = 2;
  localparam int LD_WGHT    = 3;
  localparam int INTR_SOFT  = 0;
  localparam int INTR_ABORT = 1;
  localparam int INTR_ERROR = 2;
  localparam int STS_IDLE   = 0;
  localparam int STS_BUSY   = 1;
  localparam int STS_ERROR  = 2;
  localparam int STS_LOCKED = 3;
  localparam int STS_VALID  = 4;

  // Software settings seen by the sequencer
  typedef struct packed {
    ccu_count_t rslt_size;
    ccu_count_t pckt_size;
    logic       data_loaded;
    logic       grid_loaded;
    logic       scle_loaded;
    logic       wght_loaded;
    logic       start;
    logic       intr_soft;
    logic       intr_abort;
    logic       intr_error;
  } ccu_config_t;

  // Hardware results and update strobes written back into the map
  typedef struct packed {
    ccu_status_t status;
    ccu_count_t  rslt_progress;
    ccu_count_t  iter_progress;
    ccu_count_t  iter_timer;
    ccu_count_t  iter_latency;
    ccu_count_t  oper_timer;
    ccu_count_t  oper_latency;
    logic        progress_load;
    logic        progress_clear;
    logic        done_set;
    logic        start_clear;
  } ccu_report_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_START,
    S_RUN,
    S_DONE,
    S_ERROR
  } ccu_state_e;

endpackage

/* design/ccu_register_file.sv */
`timescale 1ns/1ps

module ccu_register_file #(
  parameter int ADDR_WIDTH      = 6,
  parameter int PIPELINE_OUTPUT = 0
) (
  input  logic                    clk,
  input  logic                    rst,

  input  logic [ADDR_WIDTH-1:0]   s_axil_awaddr,
  input  logic [2:0]              s_axil_awprot,
  input  logic                    s_axil_awvalid,
  output logic                    s_axil_awready,
  input  ccu_pkg::ccu_word_t      s_axil_wdata,
  input  logic [3:0]              s_axil_wstrb,
  input  logic                    s_axil_wvalid,
  output logic                    s_axil_wready,
  output logic [1:0]              s_axil_bresp,
  output logic                    s_axil_bvalid,
  input  logic                    s_axil_bready,
  input  logic [ADDR_WIDTH-1:0]   s_axil_araddr,
  input  logic [2:0]              s_axil_arprot,
  input  logic                    s_axil_arvalid,
  output logic                    s_axil_arready,
  output ccu_pkg::ccu_word_t      s_axil_rdata,
  output logic [1:0]              s_axil_rresp,
  output logic                    s_axil_rvalid,
  input  logic                    s_axil_rready,

  input  ccu_pkg::ccu_report_t    report,
  output ccu_pkg::ccu_config_t    cfg,
  output logic                    interrupt_soft,
  output logic                    interrupt_abort,
  output logic                    interrupt_error
);

  localparam int IDX_W = $clog2(ccu_pkg::REG_WORDS);

  typedef logic [IDX_W-1:0] idx_t;

  // Word indices derived from the byte offsets
  localparam idx_t IDX_RLEN = idx_t'(ccu_pkg::REG_RSLT_LEN >> 2);
  localparam idx_t IDX_PLEN = idx_t'(ccu_pkg::REG_PCKT_LEN >> 2);
  localparam idx_t IDX_LDR  = idx_t'(ccu_pkg::REG_LOADED >> 2);
  localparam idx_t IDX_STR  = idx_t'(ccu_pkg::REG_OPER_STR >> 2);
  localparam idx_t IDX_INTR = idx_t'(ccu_pkg::REG_INTR >> 2);
  localparam idx_t IDX_DNE  = idx_t'(ccu_pkg::REG_OPER_DNE >> 2);
  localparam idx_t IDX_STS  = idx_t'(ccu_pkg::REG_OPER_STS >> 2);
  localparam idx_t IDX_RPRG = idx_t'(ccu_pkg::REG_RSLT_PRG >> 2);
  localparam idx_t IDX_IPRG = idx_t'(ccu_pkg::REG_ITER_PRG >> 2);
  localparam idx_t IDX_ITMR = idx_t'(ccu_pkg::REG_ITER_TMR >> 2);
  localparam idx_t IDX_ILAT = idx_t'(ccu_pkg::REG_ITER_LAT >> 2);
  localparam idx_t IDX_OTMR = idx_t'(ccu_pkg::REG_OPER_TMR >> 2);
  localparam idx_t IDX_OLAT = idx_t'(ccu_pkg::REG_OPER_LAT >> 2);

  ccu_pkg::ccu_word_t regs [ccu_pkg::REG_WORDS];

  logic               awready_q;
  logic               wready_q;
  logic               bvalid_q;
  logic               arready_q;
  logic               rvalid_q;
  logic               rvalid_p;
  ccu_pkg::ccu_word_t rdata_q;
  ccu_pkg::ccu_word_t rdata_p;
  logic               wr_en;
  logic               rd_en;
  logic               rd_free;
  idx_t               wr_idx;
  idx_t               rd_idx;

  function automatic ccu_pkg::ccu_word_t merge_bytes(input ccu_pkg::ccu_word_t old_word,
                                                     input ccu_pkg::ccu_word_t new_word,
                                                     input logic [3:0]         strb);
    ccu_pkg::ccu_word_t res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign wr_idx = s_axil_awaddr[IDX_W+1:2];
  assign rd_idx = s_axil_araddr[IDX_W+1:2];

  // One write per response slot, accepted only with both address and data
  assign wr_en = s_axil_awvalid && s_axil_wvalid && (!bvalid_q || s_axil_bready) &&
                 !awready_q && !wready_q;

  // The output stage frees up when it is empty or being drained
  assign rd_free = (PIPELINE_OUTPUT != 0) ? (!rvalid_p || s_axil_rready)
                                          : (!rvalid_q || s_axil_rready);
  assign rd_en   = s_axil_arvalid && rd_free && !arready_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      awready_q <= 1'b0;
      wready_q  <= 1'b0;
      bvalid_q  <= 1'b0;
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
      rvalid_p  <= 1'b0;
    end else begin
      awready_q <= wr_en;
      wready_q  <= wr_en;
      bvalid_q  <= wr_en || (bvalid_q && !s_axil_bready);
      arready_q <= rd_en;
      rvalid_q  <= rd_en || (rvalid_q && !rd_free);
      if (!rvalid_p || s_axil_rready) begin
        rvalid_p <= rvalid_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata_q <= regs[rd_idx];
    end
    if (!rvalid_p || s_axil_rready) begin
      rdata_p <= rdata_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ccu_pkg::REG_WORDS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // Start clear first so that a software write in the same cycle wins
      if (report.start_clear) begin
        regs[IDX_STR][0] <= 1'b0;
      end
      // Words above the done word are owned by hardware
      if (wr_en && wr_idx <= IDX_DNE) begin
        regs[wr_idx] <= merge_bytes(regs[wr_idx], s_axil_wdata, s_axil_wstrb);
      end
      if (report.done_set) begin
        regs[IDX_DNE][0] <= 1'b1;
      end

      regs[IDX_STS] <= ccu_pkg::ccu_word_t'(report.status);

      if (report.progress_clear) begin
        for (int i = IDX_RPRG; i <= IDX_OLAT; i++) begin
          regs[i] <= '0;
        end
      end else if (report.progress_load) begin
        regs[IDX_RPRG] <= report.rslt_progress;
        regs[IDX_IPRG] <= report.iter_progress;
        regs[IDX_ITMR] <= report.iter_timer;
        regs[IDX_ILAT] <= report.iter_latency;
        regs[IDX_OTMR] <= report.oper_timer;
        regs[IDX_OLAT] <= report.oper_latency;
      end
    end
  end

  assign s_axil_awready = awready_q;
  assign s_axil_wready  = wready_q;
  assign s_axil_bvalid  = bvalid_q;
  assign s_axil_bresp   = 2'b00;
  assign s_axil_arready = arready_q;
  assign s_axil_rvalid  = (PIPELINE_OUTPUT != 0) ? rvalid_p : rvalid_q;
  assign s_axil_rdata   = (PIPELINE_OUTPUT != 0) ? rdata_p : rdata_q;
  assign s_axil_rresp   = 2'b00;

  assign cfg.rslt_size   = regs[IDX_RLEN];
  assign cfg.pckt_size   = regs[IDX_PLEN];
  assign cfg.data_loaded = regs[IDX_LDR][ccu_pkg::LD_DATA];
  assign cfg.grid_loaded = regs[IDX_LDR][ccu_pkg::LD_GRID];
  assign cfg.scle_loaded = regs[IDX_LDR][ccu_pkg::LD_SCLE];
  assign cfg.wght_loaded = regs[IDX_LDR][ccu_pkg::LD_WGHT];
  assign cfg.start       = regs[IDX_STR][0];
  assign cfg.intr_soft   = regs[IDX_INTR][ccu_pkg::INTR_SOFT];
  assign cfg.intr_abort  = regs[IDX_INTR][ccu_pkg::INTR_ABORT];
  assign cfg.intr_error  = regs[IDX_INTR][ccu_pkg::INTR_ERROR];

  assign interrupt_soft  = cfg.intr_soft;
  assign interrupt_abort = cfg.intr_abort;
  assign interrupt_error = cfg.intr_error;

endmodule

/* design/ccu_sequencer.sv */
`timescale 1ns/1ps

module ccu_sequencer (
  input  logic                 clk,
  input  logic                 rst,
  input  ccu_pkg::ccu_config_t cfg,
  input  logic                 rslt_beat,
  input  logic                 pckt_last,
  output ccu_pkg::ccu_status_t status,
  output ccu_pkg::ccu_count_t  rslt_progress,
  output ccu_pkg::ccu_count_t  iter_progress,
  output logic                 progress_load,
  output logic                 progress_clear,
  output logic                 done_set,
  output logic                 start_clear,
  output logic                 busy
);

  ccu_pkg::ccu_state_e state_q;
  ccu_pkg::ccu_state_e state_d;
  ccu_pkg::ccu_count_t rslt_next;
  logic                all_loaded;
  logic                stop_req;
  logic                valid_q;

  assign all_loaded = cfg.data_loaded && cfg.grid_loaded &&
                      cfg.scle_loaded && cfg.wght_loaded;
  assign stop_req   = cfg.intr_abort || cfg.intr_error;
  assign rslt_next  = rslt_progress + ccu_pkg::ccu_count_t'(rslt_beat);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ccu_pkg::S_IDLE: begin
        if (cfg.start && all_loaded) begin
          state_d = ccu_pkg::S_START;
        end
      end
      ccu_pkg::S_START: begin
        state_d = stop_req ? ccu_pkg::S_ERROR : ccu_pkg::S_RUN;
      end
      ccu_pkg::S_RUN: begin
        // Finish in the cycle the last result beat arrives
        if (stop_req) begin
          state_d = ccu_pkg::S_ERROR;
        end else if (rslt_next >= cfg.rslt_size) begin
          state_d = ccu_pkg::S_DONE;
        end
      end
      ccu_pkg::S_DONE: begin
        state_d = ccu_pkg::S_IDLE;
      end
      ccu_pkg::S_ERROR: begin
        // Held until software clears the interrupt word
        if (!stop_req) begin
          state_d = ccu_pkg::S_IDLE;
        end
      end
      default: begin
        state_d = ccu_pkg::S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q       <= ccu_pkg::S_IDLE;
      rslt_progress <= '0;
      iter_progress <= '0;
      valid_q       <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == ccu_pkg::S_START) begin
        rslt_progress <= '0;
        iter_progress <= '0;
        valid_q       <= 1'b0;
      end else if (state_q == ccu_pkg::S_RUN) begin
        rslt_progress <= rslt_next;
        if (pckt_last) begin
          iter_progress <= iter_progress + 32'd1;
        end
      end
      if (state_q == ccu_pkg::S_DONE) begin
        valid_q <= 1'b1;
      end
    end
  end

  assign busy           = (state_q == ccu_pkg::S_START) || (state_q == ccu_pkg::S_RUN);
  assign progress_clear = (state_q == ccu_pkg::S_START);
  assign done_set       = (state_q == ccu_pkg::S_DONE);
  assign progress_load  = ((state_q == ccu_pkg::S_RUN) && pckt_last) || done_set;

  // Entry into the error state also drops the start bit
  assign start_clear = done_set ||
                       ((state_q != ccu_pkg::S_ERROR) && (state_d == ccu_pkg::S_ERROR));

  assign status[ccu_pkg::STS_IDLE]   = (state_q == ccu_pkg::S_IDLE);
  assign status[ccu_pkg::STS_BUSY]   = busy;
  assign status[ccu_pkg::STS_ERROR]  = (state_q == ccu_pkg::S_ERROR);
  assign status[ccu_pkg::STS_LOCKED] = busy || (state_q == ccu_pkg::S_ERROR);
  assign status[ccu_pkg::STS_VALID]  = valid_q;

endmodule

/* design/ccu_top.sv */
`timescale 1ns/1ps

module ccu_top #(
  parameter int ADDR_WIDTH      = 6,
  parameter int PIPELINE_OUTPUT = 0
) (
  input  logic                  clk,
  input  logic                  rst,

  input  logic [ADDR_WIDTH-1:0] s_axil_awaddr,
  input  logic [2:0]            s_axil_awprot,
  input  logic                  s_axil_awvalid,
  output logic                  s_axil_awready,
  input  ccu_pkg::ccu_word_t    s_axil_wdata,
  input  logic [3:0]            s_axil_wstrb,
  input  logic                  s_axil_wvalid,
  output logic                  s_axil_wready,
  output logic [1:0]            s_axil_bresp,
  output logic                  s_axil_bvalid,
  input  logic                  s_axil_bready,
  input  logic [ADDR_WIDTH-1:0] s_axil_araddr,
  input  logic [2:0]            s_axil_arprot,
  input  logic                  s_axil_arvalid,
  output logic                  s_axil_arready,
  output ccu_pkg::ccu_word_t    s_axil_rdata,
  output logic [1:0]            s_axil_rresp,
  output logic                  s_axil_rvalid,
  input  logic                  s_axil_rready,

  // Datapath strobes
  input  logic                  rslt_beat,
  input  logic                  pckt_last,

  output logic                  interrupt_soft,
  output logic                  interrupt_abort,
  output logic                  interrupt_error,
  output logic                  operation_busy
);

  ccu_pkg::ccu_config_t cfg;
  ccu_pkg::ccu_report_t report;

  ccu_register_file #(
    .ADDR_WIDTH      (ADDR_WIDTH),
    .PIPELINE_OUTPUT (PIPELINE_OUTPUT)
  ) u_register_file (
    .clk             (clk),
    .rst             (rst),
    .s_axil_awaddr   (s_axil_awaddr),
    .s_axil_awprot   (s_axil_awprot),
    .s_axil_awvalid  (s_axil_awvalid),
    .s_axil_awready  (s_axil_awready),
    .s_axil_wdata    (s_axil_wdata),
    .s_axil_wstrb    (s_axil_wstrb),
    .s_axil_wvalid   (s_axil_wvalid),
    .s_axil_wready   (s_axil_wready),
    .s_axil_bresp    (s_axil_bresp),
    .s_axil_bvalid   (s_axil_bvalid),
    .s_axil_bready   (s_axil_bready),
    .s_axil_araddr   (s_axil_araddr),
    .s_axil_arprot   (s_axil_arprot),
    .s_axil_arvalid  (s_axil_arvalid),
    .s_axil_arready  (s_axil_arready),
    .s_axil_rdata    (s_axil_rdata),
    .s_axil_rresp    (s_axil_rresp),
    .s_axil_rvalid   (s_axil_rvalid),
    .s_axil_rready   (s_axil_rready),
    .report          (report),
    .cfg             (cfg),
    .interrupt_soft  (interrupt_soft),
    .interrupt_abort (interrupt_abort),
    .interrupt_error (interrupt_error)
  );

  // Status, progress and strobes come from the sequencer
  ccu_sequencer u_sequencer (
    .clk            (clk),
    .rst            (rst),
    .cfg            (cfg),
    .rslt_beat      (rslt_beat),
    .pckt_last      (pckt_last),
    .status         (report.status),
    .rslt_progress  (report.rslt_progress),
    .iter_progress  (report.iter_progress),
    .progress_load  (report.progress_load),
    .progress_clear (report.progress_clear),
    .done_set       (report.done_set),
    .start_clear    (report.start_clear),
    .busy           (operation_busy)
  );

  // Timing fields of the report
  ccu_perf_counters u_perf_counters (
    .clk            (clk),
    .rst            (rst),
    .busy           (operation_busy),
    .pckt_last      (pckt_last),
    .done_set       (report.done_set),
    .progress_clear (report.progress_clear),
    .iter_timer     (report.iter_timer),
    .iter_latency   (report.iter_latency),
    .oper_timer     (report.oper_timer),
    .oper_latency   (report.oper_latency)
  );

endmodule

/* files.f */
design/ccu_pkg.sv
design/ccu_register_file.sv
design/ccu_sequencer.sv
design/ccu_perf_counters.sv
design/ccu_top.sv
sim/ccu_sva.sv
sim/ccu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the CCU testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found"
  exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal --top-module ccu_tb -f files.f; then
  echo "Build failed"
  exit 1
fi

output=$(./obj_dir/Vccu_tb)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1

/* sim/ccu_sva.sv */
`timescale 1ns/1ps

module ccu_sva (
  input logic               clk,
  input logic               rst,
  input logic               s_axil_awready,
  input logic               s_axil_wready,
  input logic               s_axil_bvalid,
  input logic               s_axil_bready,
  input logic               s_axil_rvalid,
  input logic               s_axil_rready,
  input ccu_pkg::ccu_word_t s_axil_rdata
);

  // A pending response stays up until the master takes it
  bvalid_held: assert property (@(posedge clk) disable iff (rst)
    s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
    else $error("bvalid dropped before bready");

  rvalid_held: assert property (@(posedge clk) disable iff (rst)
    s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid)
    else $error("rvalid dropped before rready");

  rdata_stable: assert property (@(posedge clk) disable iff (rst)
    s_axil_rvalid && !s_axil_rready |=> $stable(s_axil_rdata))
    else $error("rdata changed while rvalid waited");

  // Covers every reset cycle after the first and the cycle after release
  write_quiet_in_reset: assert property (@(posedge clk)
    $past(rst) |-> !s_axil_awready && !s_axil_wready && !s_axil_bvalid)
    else $error("write channel active during or right after reset");

endmodule

bind ccu_register_file ccu_sva u_sva (
  .clk            (clk),
  .rst            (rst),
  .s_axil_awready (s_axil_awready),
  .s_axil_wready  (s_axil_wready),
  .s_axil_bvalid  (s_axil_bvalid),
  .s_axil_bready  (s_axil_bready),
  .s_axil_rvalid  (s_axil_rvalid),
  .s_axil_rready  (s_axil_rready),
  .s_axil_rdata   (s_axil_rdata)
);

/* sim/ccu_tb.sv */
`timescale 1ns/1ps

module ccu_tb;

  localparam int ADDR_WIDTH = 6;
  localparam int TIMEOUT    = 100;
  localparam int N_BEATS    = 12;
  localparam int P_BEATS    = 4;

  logic                  clk;
  logic                  rst;
  logic [ADDR_WIDTH-1:0] s_axil_awaddr;
  logic [2:0]            s_axil_awprot;
  logic                  s_axil_awvalid;
  logic                  s_axil_awready;
  ccu_pkg::ccu_word_t    s_axil_wdata;
  logic [3:0]            s_axil_wstrb;
  logic                  s_axil_wvalid;
  logic                  s_axil_wready;
  logic [1:0]            s_axil_bresp;
  logic                  s_axil_bvalid;
  logic                  s_axil_bready;
  logic [ADDR_WIDTH-1:0] s_axil_araddr;
  logic [2:0]            s_axil_arprot;
  logic                  s_axil_arvalid;
  logic                  s_axil_arready;
  ccu_pkg::ccu_word_t    s_axil_rdata;
  logic [1:0]            s_axil_rresp;
  logic                  s_axil_rvalid;
  logic                  s_axil_rready;
  logic                  rslt_beat;
  logic                  pckt_last;
  logic                  interrupt_soft;
  logic                  interrupt_abort;
  logic                  interrupt_error;
  logic                  operation_busy;
  logic [31:0]           lfsr_state;
  int                    errors;
  int                    timeouts;

  ccu_top #(
    .ADDR_WIDTH      (ADDR_WIDTH),
    .PIPELINE_OUTPUT (1)
  ) UUT (.*);

  always #5 clk = ~clk;

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_at_least(input string name, input logic [31:0] got,
                                input logic [31:0] min);
    assert (got >= min) else begin
      $display("Error: %s is %h, expected at least %h", name, got, min);
      errors++;
    end
  endtask

  // All handshake loops run from 1 ns after a rising edge
  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    int   n;
    logic fire;
    s_axil_awaddr  = addr[ADDR_WIDTH-1:0];
    s_axil_wdata   = data;
    s_axil_wstrb   = strb;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid  = 1'b1;
    n    = 0;
    fire = 1'b0;
    while (!fire && n < TIMEOUT) begin
      fire = s_axil_awready && s_axil_wready;
      @(posedge clk);
      #1;
      n++;
    end
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    if (!fire) begin
      $display("Timeout: write to %h was never accepted", addr);
      timeouts++;
    end
    n    = 0;
    fire = 1'b0;
    while (!fire && n < TIMEOUT) begin
      s_axil_bready = rand_bits(1) != 0;
      fire = s_axil_bvalid && s_axil_bready;
      if (fire) begin
        // Every write is answered OKAY
        check_value("s_axil_bresp", 32'(s_axil_bresp), 32'h0);
      end
      @(posedge clk);
      #1;
      n++;
    end
    s_axil_bready = 1'b0;
    if (!fire) begin
      $display("Timeout: no write response for %h", addr);
      timeouts++;
    end
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
    int   n;
    logic fire;
    data           = '0;
    s_axil_araddr  = addr[ADDR_WIDTH-1:0];
    s_axil_arvalid = 1'b1;
    n    = 0;
    fire = 1'b0;
    while (!fire && n < TIMEOUT) begin
      fire = s_axil_arready;
      @(posedge clk);
      #1;
      n++;
    end
    s_axil_arvalid = 1'b0;
    if (!fire) begin
      $display("Timeout: read of %h was never accepted", addr);
      timeouts++;
    end
    n    = 0;
    fire = 1'b0;
    while (!fire && n < TIMEOUT) begin
      s_axil_rready = rand_bits(1) != 0;
      fire = s_axil_rvalid && s_axil_rready;
      if (fire) begin
        data = s_axil_rdata;
        check_value("s_axil_rresp", 32'(s_axil_rresp), 32'h0);
      end
      @(posedge clk);
      #1;
      n++;
    end
    s_axil_rready = 1'b0;
    if (!fire) begin
      $display("Timeout: no read data for %h", addr);
      timeouts++;
    end
  endtask

  task automatic read_check(input string name, input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    axil_read(addr, got);
    check_value(name, got, exp);
  endtask

  task automatic poll_word(input string name, input logic [7:0] addr,
                           input logic [31:0] mask, output logic [31:0] value);
    int n;
    n = 0;
    axil_read(addr, value);
    while ((value & mask) == 0 && n < TIMEOUT) begin
      axil_read(addr, value);
      n++;
    end
    if ((value & mask) == 0) begin
      $display("Timeout: %s never showed bits %h", name, mask);
      timeouts++;
    end
  endtask

  // START lasts one cycle, so beats are sent from the cycle after it
  task automatic wait_for_run();
    int n;
    n = 0;
    while (!operation_busy && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!operation_busy) begin
      $display("Timeout: operation_busy never rose after start");
      timeouts++;
    end
    @(posedge clk);
    #1;
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] wd;
    logic [3:0]  ws;
    logic [7:0]  addr;
    logic [31:0] model [5];
    clk            = 1'b0;
    rst            = 1'b1;
    s_axil_awaddr  = '0;
    s_axil_awprot  = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = '0;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b0;
    s_axil_araddr  = '0;
    s_axil_arprot  = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b0;
    rslt_beat      = 1'b0;
    pckt_last      = 1'b0;
    lfsr_state     = 32'h5810;
    errors         = 0;
    timeouts       = 0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    // Map is clear after reset, apart from the idle bit copied into status
    for (int i = 0; i < ccu_pkg::REG_WORDS; i++) begin
      addr = 8'(i * 4);
      read_check($sformatf("word %h", addr), addr,
                 (addr == ccu_pkg::REG_OPER_STS) ? 32'h1 : 32'h0);
    end
    check_value("interrupt lines",
                {29'd0, interrupt_error, interrupt_abort, interrupt_soft}, 32'h0);

    // Size words merge byte by byte under the write strobes
    for (int w = 0; w < 5; w++) begin
      model[w] = '0;
    end
    for (int r = 0; r < 3; r++) begin
      for (int w = 0; w < 5; w++) begin
        addr = 8'(w * 4);
        wd   = rand_bits(32);
        ws   = 4'(rand_bits(4));
        axil_write(addr, wd, ws);
        for (int b = 0; b < 4; b++) begin
          if (ws[b]) begin
            model[w][8*b +: 8] = wd[8*b +: 8];
          end
        end
        read_check($sformatf("word %h", addr), addr, model[w]);
      end
    end

    // Hardware words ignore software writes
    for (int i = 9; i < ccu_pkg::REG_WORDS; i++) begin
      addr = 8'(i * 4);
      axil_write(addr, rand_bits(32), 4'hF);
      read_check($sformatf("word %h", addr), addr,
                 (addr == ccu_pkg::REG_OPER_STS) ? 32'h1 : 32'h0);
    end

    for (int k = 0; k < 4; k++) begin
      wd = rand_bits(3);
      axil_write(ccu_pkg::REG_INTR, wd, 4'hF);
      check_value("interrupt lines",
                  {29'd0, interrupt_error, interrupt_abort, interrupt_soft}, wd);
      read_check("REG_INTR", ccu_pkg::REG_INTR, wd);
    end
    axil_write(ccu_pkg::REG_INTR, 32'h0, 4'hF);

    // Full operation with random gaps between beats
    axil_write(ccu_pkg::REG_RSLT_LEN, N_BEATS, 4'hF);
    axil_write(ccu_pkg::REG_PCKT_LEN, P_BEATS, 4'hF);
    axil_write(ccu_pkg::REG_LOADED, 32'hF, 4'hF);
    axil_write(ccu_pkg::REG_OPER_STR, 32'h1, 4'hF);
    wait_for_run();
    for (int b = 1; b <= N_BEATS; b++) begin
      rslt_beat = 1'b1;
      pckt_last = (b % P_BEATS) == 0;
      @(posedge clk);
      #1;
      rslt_beat = 1'b0;
      pckt_last = 1'b0;
      if (rand_bits(1) != 0) begin
        @(posedge clk);
        #1;
      end
    end
    poll_word("REG_OPER_DNE", ccu_pkg::REG_OPER_DNE, 32'h1, rd);
    read_check("REG_OPER_DNE", ccu_pkg::REG_OPER_DNE, 32'h1);
    read_check("REG_OPER_STR", ccu_pkg::REG_OPER_STR, 32'h0);
    read_check("REG_OPER_STS", ccu_pkg::REG_OPER_STS, 32'h11);
    read_check("REG_RSLT_PRG", ccu_pkg::REG_RSLT_PRG, N_BEATS);
    read_check("REG_ITER_PRG", ccu_pkg::REG_ITER_PRG, N_BEATS / P_BEATS);
    axil_read(ccu_pkg::REG_OPER_LAT, rd);
    check_at_least("REG_OPER_LAT", rd, N_BEATS);
    axil_read(ccu_pkg::REG_ITER_LAT, rd);
    check_at_least("REG_ITER_LAT", rd, P_BEATS);

    // Weights flag missing, so start must be ignored
    axil_write(ccu_pkg::REG_LOADED, 32'h7, 4'hF);
    axil_write(ccu_pkg::REG_OPER_STR, 32'h1, 4'hF);
    for (int k = 0; k < 4; k++) begin
      check_value("operation_busy", {31'd0, operation_busy}, 32'h0);
      @(posedge clk);
      #1;
    end
    // Valid stays set from the previous operation
    read_check("REG_OPER_STS", ccu_pkg::REG_OPER_STS, 32'h11);
    axil_write(ccu_pkg::REG_OPER_STR, 32'h0, 4'hF);

    // Abort in the middle of a long run
    axil_write(ccu_pkg::REG_RSLT_LEN, 32'd1000, 4'hF);
    axil_write(ccu_pkg::REG_LOADED, 32'hF, 4'hF);
    axil_write(ccu_pkg::REG_OPER_STR, 32'h1, 4'hF);
    wait_for_run();
    for (int b = 0; b < 3; b++) begin
      rslt_beat = 1'b1;
      @(posedge clk);
      #1;
      rslt_beat = 1'b0;
    end
    axil_write(ccu_pkg::REG_INTR, 32'h2, 4'hF);
    poll_word("REG_OPER_STS", ccu_pkg::REG_OPER_STS, 32'h4, rd);
    check_value("REG_OPER_STS", rd, 32'h0C);
    check_value("interrupt_abort", {31'd0, interrupt_abort}, 32'h1);
    read_check("REG_OPER_STR", ccu_pkg::REG_OPER_STR, 32'h0);
    axil_write(ccu_pkg::REG_INTR, 32'h0, 4'hF);
    poll_word("REG_OPER_STS", ccu_pkg::REG_OPER_STS, 32'h1, rd);
    check_value("REG_OPER_STS", rd, 32'h01);

    $display("Finished with %0d value errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
